// ==== source/fads_frontend_settings.svh ====
`ifndef FADS_FRONTEND_SETTINGS_SVH
`define FADS_FRONTEND_SETTINGS_SVH

//////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////

`define SAMPLE_W    14              // adc / dac sample width
`define BUS_W       32              // system bus data and address

//////////////////////////////////////////////////
// system bus map
//////////////////////////////////////////////////

`define REGION_MSB  22              // region field, 8 regions
`define REGION_LSB  20
`define OFS_W       20              // offset field below the region bits

`define HK_ID       32'h4641_4453   // read-only id word in region 0

//////////////////////////////////////////////////
// multiplexer sequencer
//////////////////////////////////////////////////

`define MUX_ADDR_W  3               // S2..S0 on the mux board
`define MUX_CH_W    6               // active channel mask
`define MUX_SETTLE  4               // cycles before the signal is stable
`define DWELL_W     16              // dwell counter width
`define DWELL_RST   16              // dwell length after reset

`endif

// ==== source/fads_frontend_pkg.sv ====
`include "fads_frontend_settings.svh"

package fads_frontend_pkg;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;  // two's complement
  typedef logic        [`SAMPLE_W-1:0] pin_word_t; // neg-slope offset binary

  // address bits 22:20
  typedef enum logic [2:0] {
    REG_HK     = 3'd0,
    REG_FREE_1 = 3'd1,
    REG_FREE_2 = 3'd2,
    REG_FREE_3 = 3'd3,
    REG_FREE_4 = 3'd4,
    REG_FREE_5 = 3'd5,
    REG_MUX    = 3'd6,
    REG_FREE_7 = 3'd7
  } region_e;

  typedef enum logic [`OFS_W-1:0] {
    HK_ID    = 'h0,
    HK_CTRL  = 'h4,   // bit 0 digital loop
    HK_OFS_A = 'h8,
    HK_OFS_B = 'hC
  } hk_reg_e;

  typedef enum logic [`OFS_W-1:0] {
    MUX_ACTIVE    = 'h0,
    MUX_DWELL_LEN = 'h4
  } mux_reg_e;

  typedef enum logic [1:0] {
    MUX_IDLE,
    MUX_SETTLE,
    MUX_DWELL
  } mux_state_e;

  // sign bit kept, the rest inverted; the rule is its own inverse
  function automatic sample_t to_sample(input pin_word_t pin);
    return sample_t'({pin[`SAMPLE_W-1], ~pin[`SAMPLE_W-2:0]});
  endfunction

  function automatic pin_word_t to_pin(input sample_t smp);
    return pin_word_t'({smp[`SAMPLE_W-1], ~smp[`SAMPLE_W-2:0]});
  endfunction

endpackage

// ==== source/sys_bus_decoder.sv ====
`timescale 1ns/1ns
`include "fads_frontend_settings.svh"

module sys_bus_decoder (
  input  logic              adc_clk,
  input  logic              reset_i,
  input  logic [`BUS_W-1:0] sys_addr_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  input  logic [`BUS_W-1:0] hk_rdata_i,
  input  logic              hk_ack_i,
  input  logic              hk_err_i,
  input  logic [`BUS_W-1:0] mux_rdata_i,
  input  logic              mux_ack_i,
  input  logic              mux_err_i,
  output logic              hk_wen_o,
  output logic              hk_ren_o,
  output logic              mux_wen_o,
  output logic              mux_ren_o,
  output logic [`BUS_W-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o
);
  import fads_frontend_pkg::*;

  region_e region;    // region of the current access
  region_e region_q;  // region of last strobe, routes the answer
  logic    strobe;
  logic    unused;

  assign region = region_e'(sys_addr_i[`REGION_MSB:`REGION_LSB]);
  assign strobe = sys_wen_i | sys_ren_i;
  assign unused = (region != REG_HK) && (region != REG_MUX);

  // strobe fan-out
  assign hk_wen_o  = sys_wen_i && (region == REG_HK);
  assign hk_ren_o  = sys_ren_i && (region == REG_HK);
  assign mux_wen_o = sys_wen_i && (region == REG_MUX);
  assign mux_ren_o = sys_ren_i && (region == REG_MUX);

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      region_q <= REG_HK;
    else if (strobe)
      region_q <= region;   // held until the next access
  end

  //////////////////////////////////////////////////
  // answer merge
  //////////////////////////////////////////////////

  always_comb
  begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    if (strobe && unused)
      sys_ack_o = 1'b1;          // free region, same-cycle zero answer
    else if (region_q == REG_HK)
    begin
      sys_rdata_o = hk_rdata_i;
      sys_ack_o   = hk_ack_i;
      sys_err_o   = hk_err_i;
    end
    else if (region_q == REG_MUX)
    begin
      sys_rdata_o = mux_rdata_i;
      sys_ack_o   = mux_ack_i;
      sys_err_o   = mux_err_i;
    end
  end

endmodule

// ==== source/hk_regs.sv ====
`timescale 1ns/1ns
`include "fads_frontend_settings.svh"

module hk_regs (
  input  logic                        adc_clk,
  input  logic                        reset_i,
  input  logic [`BUS_W-1:0]           sys_addr_i,
  input  logic [`BUS_W-1:0]           sys_wdata_i,
  input  logic                        sys_wen_i,
  input  logic                        sys_ren_i,
  output logic [`BUS_W-1:0]           sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        sys_err_o,
  output logic                        loop_en_o,
  output fads_frontend_pkg::sample_t  offset_a_o,
  output fads_frontend_pkg::sample_t  offset_b_o
);
  import fads_frontend_pkg::*;

  hk_reg_e ofs;
  logic    loop_en_q;
  sample_t offset_a_q;
  sample_t offset_b_q;

  assign ofs = hk_reg_e'(sys_addr_i[`OFS_W-1:0]);

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      loop_en_q   <= 1'b0;
      offset_a_q  <= '0;
      offset_b_q  <= '0;
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // answer one cycle later
      sys_err_o <= 1'b0;
      if (sys_wen_i)
      begin
        case (ofs)
          HK_ID    : ;                                   // read only
          HK_CTRL  : loop_en_q  <= sys_wdata_i[0];
          HK_OFS_A : offset_a_q <= sample_t'(sys_wdata_i[`SAMPLE_W-1:0]);
          HK_OFS_B : offset_b_q <= sample_t'(sys_wdata_i[`SAMPLE_W-1:0]);
          default  : sys_err_o  <= 1'b1;
        endcase
      end
      if (sys_ren_i)
      begin
        case (ofs)
          HK_ID    : sys_rdata_o <= `HK_ID;
          HK_CTRL  : sys_rdata_o <= {{(`BUS_W-1){1'b0}}, loop_en_q};
          HK_OFS_A : sys_rdata_o <= {{(`BUS_W-`SAMPLE_W){offset_a_q[`SAMPLE_W-1]}}, offset_a_q};
          HK_OFS_B : sys_rdata_o <= {{(`BUS_W-`SAMPLE_W){offset_b_q[`SAMPLE_W-1]}}, offset_b_q};
          default  :
          begin
            sys_rdata_o <= '0;
            sys_err_o   <= 1'b1;   // not in the map
          end
        endcase
      end
    end
  end

  assign loop_en_o  = loop_en_q;
  assign offset_a_o = offset_a_q;
  assign offset_b_o = offset_b_q;

endmodule

// ==== source/channel_path.sv ====
`timescale 1ns/1ns
`include "fads_frontend_settings.svh"

module channel_path (
  input  logic                         adc_clk,
  input  logic                         reset_i,
  input  fads_frontend_pkg::pin_word_t adc_dat_i,
  input  logic                         loop_en_i,
  input  fads_frontend_pkg::sample_t   offset_i,
  output fads_frontend_pkg::sample_t   sample_o
);
  import fads_frontend_pkg::*;

  pin_word_t                 pin_q;     // io register, no reset
  sample_t                   adc_s;
  sample_t                   src_s;
  logic signed [`SAMPLE_W:0] sum;       // one guard bit
  sample_t                   sat_s;
  sample_t                   sample_q;

  always_ff @(posedge adc_clk)
    pin_q <= adc_dat_i;

  assign adc_s = to_sample(pin_q);                // neg slope to two's complement
  assign src_s = loop_en_i ? sample_q : adc_s;    // digital loop takes own output
  assign sum   = {src_s[`SAMPLE_W-1], src_s} + {offset_i[`SAMPLE_W-1], offset_i};

  // guard and top bit disagree on overflow
  always_comb
  begin
    if (!sum[`SAMPLE_W] && sum[`SAMPLE_W-1])
      sat_s = {1'b0, {(`SAMPLE_W-1){1'b1}}};       // +8191
    else if (sum[`SAMPLE_W] && !sum[`SAMPLE_W-1])
      sat_s = {1'b1, {(`SAMPLE_W-1){1'b0}}};       // -8192
    else
      sat_s = sum[`SAMPLE_W-1:0];
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      sample_q <= '0;
    else
      sample_q <= sat_s;
  end

  assign sample_o = sample_q;

endmodule

// ==== source/dac_serializer.sv ====
`timescale 1ns/1ns

module dac_serializer (
  input  logic                         adc_clk,
  input  logic                         reset_i,
  input  fads_frontend_pkg::sample_t   sample_a_i,
  input  fads_frontend_pkg::sample_t   sample_b_i,
  output fads_frontend_pkg::pin_word_t dac_dat_o,
  output logic                         dac_sel_o,
  output logic                         dac_rst_o
);
  import fads_frontend_pkg::*;

  logic      sel_q;
  pin_word_t dat_q;
  logic      rst_q;

  // data picked by the next select value, so both flops stay aligned
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      sel_q <= 1'b0;
      dat_q <= to_pin('0);              // midscale, 0x1FFF
    end
    else
    begin
      sel_q <= ~sel_q;                  // interleave a / b
      dat_q <= ~sel_q ? to_pin(sample_b_i)   // sel high carries b
                      : to_pin(sample_a_i);
    end
  end

  always_ff @(posedge adc_clk)
    rst_q <= reset_i;                   // dac reset follows one cycle late

  assign dac_dat_o = dat_q;
  assign dac_sel_o = sel_q;
  assign dac_rst_o = rst_q;

endmodule

// ==== source/mux_sequencer.sv ====
`timescale 1ns/1ns
`include "fads_frontend_settings.svh"

module mux_sequencer (
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  logic [`BUS_W-1:0]      sys_addr_i,
  input  logic [`BUS_W-1:0]      sys_wdata_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  output logic [`BUS_W-1:0]      sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o,
  output logic [`MUX_ADDR_W-1:0] mux_addr_o,
  output logic                   signal_stable_o
);
  import fads_frontend_pkg::*;

  mux_reg_e               ofs;
  logic [`MUX_CH_W-1:0]   active_q;
  logic [`DWELL_W-1:0]    dwell_q;
  logic                   wr_active;
  mux_state_e             state_q;
  logic [`DWELL_W-1:0]    cnt_q;
  logic [`MUX_ADDR_W-1:0] addr_q;

  // next higher enabled channel after cur, wrapping at the mask width
  function automatic logic [`MUX_ADDR_W-1:0] next_ch(input logic [`MUX_CH_W-1:0]   mask,
                                                      input logic [`MUX_ADDR_W-1:0] cur);
    logic [`MUX_ADDR_W-1:0] ch;
    logic                   found;
    ch      = cur;
    found   = 1'b0;
    next_ch = cur;
    for (int i = 0; i < `MUX_CH_W; i++)
    begin
      ch = (ch == `MUX_ADDR_W'(`MUX_CH_W-1)) ? '0 : ch + 1'b1;
      if (!found && mask[ch])
      begin
        next_ch = ch;
        found   = 1'b1;
      end
    end
  endfunction

  assign ofs       = mux_reg_e'(sys_addr_i[`OFS_W-1:0]);
  assign wr_active = sys_wen_i && (ofs == MUX_ACTIVE);

  //////////////////////////////////////////////////
  // region 6 registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      active_q    <= '0;
      dwell_q     <= `DWELL_W'(`DWELL_RST);
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      sys_err_o <= (sys_wen_i | sys_ren_i) && (ofs != MUX_ACTIVE) && (ofs != MUX_DWELL_LEN);
      if (wr_active)
        active_q <= sys_wdata_i[`MUX_CH_W-1:0];
      if (sys_wen_i && (ofs == MUX_DWELL_LEN))
        dwell_q <= sys_wdata_i[`DWELL_W-1:0];
      if (sys_ren_i)
      begin
        case (ofs)
          MUX_ACTIVE    : sys_rdata_o <= `BUS_W'(active_q);
          MUX_DWELL_LEN : sys_rdata_o <= `BUS_W'(dwell_q);
          default       : sys_rdata_o <= '0;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // channel walk
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      state_q <= MUX_IDLE;
      cnt_q   <= '0;
      addr_q  <= '0;
    end
    else if (wr_active)             // new mask restarts at lowest channel
    begin
      cnt_q <= '0;
      if (sys_wdata_i[`MUX_CH_W-1:0] == '0)
      begin
        state_q <= MUX_IDLE;
        addr_q  <= '0;
      end
      else
      begin
        state_q <= MUX_SETTLE;
        addr_q  <= next_ch(sys_wdata_i[`MUX_CH_W-1:0], `MUX_ADDR_W'(`MUX_CH_W-1));
      end
    end
    else
    begin
      case (state_q)
        MUX_IDLE : ;                  // empty mask, waits for a mask write
        MUX_SETTLE :
        begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == `DWELL_W'(`MUX_SETTLE-1))
          begin
            state_q <= MUX_DWELL;     // analog path has settled
            cnt_q   <= '0;
          end
        end
        default :
        begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q + 1'b1 >= dwell_q)  // zero dwell acts as one
          begin
            state_q <= MUX_SETTLE;
            addr_q  <= next_ch(active_q, addr_q);
            cnt_q   <= '0;
          end
        end
      endcase
    end
  end

  assign mux_addr_o      = addr_q;
  assign signal_stable_o = (state_q == MUX_DWELL);

endmodule

// ==== source/fads_frontend_top.sv ====
`timescale 1ns/1ns
`include "fads_frontend_settings.svh"

module fads_frontend_top (
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  logic [`SAMPLE_W-1:0]   adc_dat_a_i,    // adc ch1 pins
  input  logic [`SAMPLE_W-1:0]   adc_dat_b_i,    // adc ch2 pins
  input  logic [`BUS_W-1:0]      sys_addr_i,
  input  logic [`BUS_W-1:0]      sys_wdata_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  output logic [`BUS_W-1:0]      sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o,
  output logic [`SAMPLE_W-1:0]   dac_dat_o,      // interleaved dac word
  output logic                   dac_sel_o,
  output logic                   dac_rst_o,
  output logic [`MUX_ADDR_W-1:0] mux_addr_o,     // S2..S0
  output logic                   signal_stable_o
);

  logic                        hk_wen, hk_ren, hk_ack, hk_err;
  logic                        mux_wen, mux_ren, mux_ack, mux_err;
  logic [`BUS_W-1:0]           hk_rdata;
  logic [`BUS_W-1:0]           mux_rdata;
  logic                        loop_en;
  logic        [`SAMPLE_W-1:0] adc_pin [2];
  logic signed [`SAMPLE_W-1:0] offset  [2];
  logic signed [`SAMPLE_W-1:0] sample  [2];

  //////////////////////////////////////////////////
  // bus decode and slaves
  //////////////////////////////////////////////////

  sys_bus_decoder u_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err),
    .mux_rdata_i (mux_rdata),
    .mux_ack_i   (mux_ack),
    .mux_err_i   (mux_err),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .mux_wen_o   (mux_wen),
    .mux_ren_o   (mux_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  hk_regs u_hk_regs (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (hk_wen),
    .sys_ren_i   (hk_ren),
    .sys_rdata_o (hk_rdata),
    .sys_ack_o   (hk_ack),
    .sys_err_o   (hk_err),
    .loop_en_o   (loop_en),
    .offset_a_o  (offset[0]),
    .offset_b_o  (offset[1])
  );

  mux_sequencer u_mux_sequencer (
    .adc_clk         (adc_clk),
    .reset_i         (reset_i),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_wen_i       (mux_wen),
    .sys_ren_i       (mux_ren),
    .sys_rdata_o     (mux_rdata),
    .sys_ack_o       (mux_ack),
    .sys_err_o       (mux_err),
    .mux_addr_o      (mux_addr_o),
    .signal_stable_o (signal_stable_o)
  );

  //////////////////////////////////////////////////
  // analog channels
  //////////////////////////////////////////////////

  assign adc_pin[0] = adc_dat_a_i;
  assign adc_pin[1] = adc_dat_b_i;

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    channel_path u_channel_path (
      .adc_clk   (adc_clk),
      .reset_i   (reset_i),
      .adc_dat_i (adc_pin[ch]),
      .loop_en_i (loop_en),      // shared digital loop bit
      .offset_i  (offset[ch]),
      .sample_o  (sample[ch])
    );
  end

  dac_serializer u_dac_serializer (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .sample_a_i (sample[0]),
    .sample_b_i (sample[1]),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o),
    .dac_rst_o  (dac_rst_o)
  );

endmodule

// ==== dv/fads_frontend_tb.sv ====
`timescale 1ns/1ns
`include "fads_frontend_settings.svh"

module fads_frontend_tb;
  import fads_frontend_pkg::*;

  localparam int N_FIXED     = 6;
  localparam int N_RANDOM    = 10;
  localparam int N_ROWS      = N_FIXED + N_RANDOM;
  localparam int LOOP_CYCLES = 200;       // loopback wait per direction
  localparam int ACK_LIMIT   = 8;         // cycles allowed for a bus answer
  localparam int MUX_DWELL_CYC = 8;       // dwell count for the mux walk
  // about 20 cycles per row, both loopback waits, reset, bus map and mux
  localparam int TIMEOUT_CYCLES = N_ROWS * 20 + 2 * LOOP_CYCLES + 400;
  localparam int S_MAX = 2 ** (`SAMPLE_W - 1) - 1;   // +8191
  localparam int S_MIN = -(2 ** (`SAMPLE_W - 1));    // -8192

  localparam logic [`BUS_W-1:0] HK_BASE   = `BUS_W'(0) << `REGION_LSB;
  localparam logic [`BUS_W-1:0] FREE_BASE = `BUS_W'(3) << `REGION_LSB;  // unused region
  localparam logic [`BUS_W-1:0] MUX_BASE  = `BUS_W'(6) << `REGION_LSB;

  typedef struct packed {
    pin_word_t pin_a;
    pin_word_t pin_b;
    sample_t   ofs_a;
    sample_t   ofs_b;
    pin_word_t exp_a;   // dac word while sel low
    pin_word_t exp_b;   // dac word while sel high
  } row_t;

  logic                   adc_clk;
  logic                   reset_i;
  pin_word_t              adc_dat_a_i;
  pin_word_t              adc_dat_b_i;
  logic [`BUS_W-1:0]      sys_addr_i;
  logic [`BUS_W-1:0]      sys_wdata_i;
  logic                   sys_wen_i;
  logic                   sys_ren_i;
  logic [`BUS_W-1:0]      sys_rdata_o;
  logic                   sys_ack_o;
  logic                   sys_err_o;
  pin_word_t              dac_dat_o;
  logic                   dac_sel_o;
  logic                   dac_rst_o;
  logic [`MUX_ADDR_W-1:0] mux_addr_o;
  logic                   signal_stable_o;

  row_t rows [N_ROWS];
  int   n_rows    = 0;
  int   seed      = 32'h2983_875a;
  int   err_cnt   = 0;
  int   chk_cnt   = 0;
  int   test_cnt  = 0;
  int   test_err0 = 0;     // error count at start of current test
  int   cycle_cnt = 0;

  fads_frontend_top u_fads_frontend_top (
    .adc_clk         (adc_clk),
    .reset_i         (reset_i),
    .adc_dat_a_i     (adc_dat_a_i),
    .adc_dat_b_i     (adc_dat_b_i),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_wen_i       (sys_wen_i),
    .sys_ren_i       (sys_ren_i),
    .sys_rdata_o     (sys_rdata_o),
    .sys_ack_o       (sys_ack_o),
    .sys_err_o       (sys_err_o),
    .dac_dat_o       (dac_dat_o),
    .dac_sel_o       (dac_sel_o),
    .dac_rst_o       (dac_rst_o),
    .mux_addr_o      (mux_addr_o),
    .signal_stable_o (signal_stable_o)
  );

  initial
    adc_clk = 1'b0;

  always #50 adc_clk = ~adc_clk;   // 100 ns period

  always @(posedge adc_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout, run stopped after %0d cycles", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////

  // pin p stands for 8191 - p, so pin = 8191 - clamp(8191 - pin + ofs)
  function automatic pin_word_t expect_word(input pin_word_t pin, input int ofs);
    int val;
    val = S_MAX - int'(pin) + ofs;
    if (val > S_MAX)
      val = S_MAX;
    else if (val < S_MIN)
      val = S_MIN;
    return pin_word_t'(S_MAX - val);
  endfunction

  task automatic check_word(input string name, input pin_word_t got, input pin_word_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%04h, expected 0x%04h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bus(input string name, input logic [`BUS_W-1:0] got, input logic got_err,
                           input logic [`BUS_W-1:0] exp, input logic exp_err);
    chk_cnt++;
    if ((got !== exp) || (got_err !== exp_err))
    begin
      $display("[FAIL] %s: data 0x%08h err 0x%h, expected 0x%08h err 0x%h",
               name, got, got_err, exp, exp_err);
      err_cnt++;
    end
  endtask

  task automatic check_mux(input string name, input logic [`MUX_ADDR_W-1:0] got,
                           input logic [`MUX_ADDR_W-1:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    chk_cnt++;
    if (got != exp)
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // bus and data path helpers
  //////////////////////////////////////////////////

  // one-cycle strobe, then wait for ack; free regions answer in the strobe cycle
  task automatic bus_access(input logic we, input logic [`BUS_W-1:0] addr,
                            input logic [`BUS_W-1:0] wdata,
                            output logic [`BUS_W-1:0] rdata, output logic err);
    int      waited;
    int      lat;
    int      exp_lat;
    logic    got_ack;
    region_e reg_sel;
    waited  = 0;
    lat     = 0;
    got_ack = 1'b0;
    rdata   = '0;
    err     = 1'b0;
    reg_sel = region_e'(addr[`REGION_MSB:`REGION_LSB]);
    exp_lat = ((reg_sel == REG_HK) || (reg_sel == REG_MUX)) ? 1 : 0;  // slaves answer late
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= we;
    sys_ren_i   <= ~we;
    @(negedge adc_clk);
    if (sys_ack_o)
    begin
      got_ack = 1'b1;
      rdata   = sys_rdata_o;
      err     = sys_err_o;
    end
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    while (!got_ack && (waited < ACK_LIMIT))
    begin
      @(negedge adc_clk);
      waited++;
      if (sys_ack_o)
      begin
        got_ack = 1'b1;
        lat     = waited;
        rdata   = sys_rdata_o;
        err     = sys_err_o;
      end
    end
    if (!got_ack)
    begin
      $display("no bus ack within %0d cycles for address 0x%08h", ACK_LIMIT, addr);
      err_cnt++;
    end
    else
      check_cycles($sformatf("sys_ack_o delay at 0x%08h", addr), lat, exp_lat);
  endtask

  task automatic capture_words(output pin_word_t wa, output pin_word_t wb);
    wa = '0;
    wb = '0;
    repeat (2)
    begin
      @(negedge adc_clk);
      if (dac_sel_o)
        wb = dac_dat_o;   // sel high is channel b
      else
        wa = dac_dat_o;
    end
  endtask

  task automatic add_row(input pin_word_t pa, input pin_word_t pb, input int oa, input int ob,
                         input pin_word_t ea, input pin_word_t eb);
    row_t r;
    r.pin_a = pa;
    r.pin_b = pb;
    r.ofs_a = sample_t'(oa);
    r.ofs_b = sample_t'(ob);
    r.exp_a = ea;
    r.exp_b = eb;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic add_random_row();
    pin_word_t pa;
    pin_word_t pb;
    sample_t   oa;
    sample_t   ob;
    pa = pin_word_t'($random(seed));
    pb = pin_word_t'($random(seed));
    oa = sample_t'($random(seed));
    ob = sample_t'($random(seed));
    add_row(pa, pb, int'(oa), int'(ob), expect_word(pa, int'(oa)), expect_word(pb, int'(ob)));
  endtask

  task automatic apply_row(input int idx);
    row_t              r;
    logic [`BUS_W-1:0] rd;
    logic              er;
    pin_word_t         wa;
    pin_word_t         wb;
    r = rows[idx];
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_A),
               {{(`BUS_W-`SAMPLE_W){r.ofs_a[`SAMPLE_W-1]}}, r.ofs_a}, rd, er);
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_B),
               {{(`BUS_W-`SAMPLE_W){r.ofs_b[`SAMPLE_W-1]}}, r.ofs_b}, rd, er);
    @(posedge adc_clk);
    adc_dat_a_i <= r.pin_a;
    adc_dat_b_i <= r.pin_b;
    repeat (4) @(posedge adc_clk);   // pin reg, sum reg, dac reg, one spare
    capture_words(wa, wb);
    check_word($sformatf("row %0d dac_dat_o a", idx), wa, r.exp_a);
    check_word($sformatf("row %0d dac_dat_o b", idx), wb, r.exp_b);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin : main
    logic [`BUS_W-1:0]      rd;
    logic                   er;
    pin_word_t              wa;
    pin_word_t              wb;
    logic                   prev;
    int                     seen;
    int                     waited;
    int                     high_cnt;
    int                     rise_at [4];
    logic [`MUX_ADDR_W-1:0] seq [4];

    reset_i     = 1'b1;
    adc_dat_a_i = 14'h1FFF;   // midscale on both pins
    adc_dat_b_i = 14'h1FFF;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;

    // pin a, pin b, offset a, offset b, dac a, dac b
    add_row(14'h1FFF, 14'h1FFF,     0,     0, 14'h1FFF, 14'h1FFF);
    add_row(14'h0000, 14'h3FFF,     0,     0, 14'h0000, 14'h3FFF);  // full scale
    add_row(14'h1000, 14'h2800,   100,  -100, 14'h0F9C, 14'h2864);
    add_row(14'h0000, 14'h3FFF,   500,  -500, 14'h0000, 14'h3FFF);  // clamp both ends
    add_row(14'h0100, 14'h3F00,  8191, -8192, 14'h0000, 14'h3FFF);
    add_row(14'h2000, 14'h1FFE,     1,    -1, 14'h1FFF, 14'h1FFF);  // around zero
    for (int i = 0; i < N_RANDOM; i++)
      add_random_row();

    // reset
    repeat (8) @(posedge adc_clk);
    @(negedge adc_clk);
    check_bit("dac_rst_o in reset", dac_rst_o, 1'b1);
    repeat (8) @(posedge adc_clk);
    reset_i <= 1'b0;
    repeat (4) @(posedge adc_clk);
    capture_words(wa, wb);
    check_word("dac_dat_o a after reset", wa, 14'h1FFF);
    check_word("dac_dat_o b after reset", wb, 14'h1FFF);
    check_bit("dac_rst_o after reset", dac_rst_o, 1'b0);
    end_test("reset");

    // bus map
    bus_access(1'b0, HK_BASE | `BUS_W'(HK_ID), '0, rd, er);
    check_bus("hk id read", rd, er, 32'h4641_4453, 1'b0);
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_ID), 32'h1234_5678, rd, er);
    check_bit("hk id write err", er, 1'b0);
    bus_access(1'b0, FREE_BASE, '0, rd, er);
    check_bus("free region read", rd, er, 32'h0, 1'b0);
    bus_access(1'b0, HK_BASE | 32'h10, '0, rd, er);
    check_bit("hk 0x10 err", er, 1'b1);
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_A), 32'hFFFF_FFFB, rd, er);
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_B), 32'h0000_04D2, rd, er);
    bus_access(1'b0, HK_BASE | `BUS_W'(HK_OFS_A), '0, rd, er);
    check_bus("offset a readback", rd, er, 32'hFFFF_FFFB, 1'b0);   // -5 sign-extended
    bus_access(1'b0, HK_BASE | `BUS_W'(HK_OFS_B), '0, rd, er);
    check_bus("offset b readback", rd, er, 32'h0000_04D2, 1'b0);
    end_test("bus map");

    // data path table
    for (int i = 0; i < n_rows; i++)
      apply_row(i);
    end_test("data path");

    // loopback, a runs into both rails
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_A), 32'd100, rd, er);
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_CTRL), 32'h1, rd, er);
    bus_access(1'b0, HK_BASE | `BUS_W'(HK_CTRL), '0, rd, er);
    check_bus("ctrl readback", rd, er, 32'h1, 1'b0);
    repeat (LOOP_CYCLES) @(posedge adc_clk);
    capture_words(wa, wb);
    check_word("loop dac_dat_o a high rail", wa, 14'h0000);   // +8191
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_A), 32'hFFFF_FF9C, rd, er);
    repeat (LOOP_CYCLES) @(posedge adc_clk);
    capture_words(wa, wb);
    check_word("loop dac_dat_o a low rail", wa, 14'h3FFF);    // -8192
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_CTRL), 32'h0, rd, er);
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_A), 32'h0, rd, er);
    bus_access(1'b1, HK_BASE | `BUS_W'(HK_OFS_B), 32'h0, rd, er);
    end_test("loopback");

    // mux walk over channels 0, 3, 5
    bus_access(1'b1, MUX_BASE | `BUS_W'(MUX_DWELL_LEN), `BUS_W'(MUX_DWELL_CYC), rd, er);
    bus_access(1'b0, MUX_BASE | `BUS_W'(MUX_DWELL_LEN), '0, rd, er);
    check_bus("dwell readback", rd, er, `BUS_W'(MUX_DWELL_CYC), 1'b0);
    bus_access(1'b1, MUX_BASE | `BUS_W'(MUX_ACTIVE), 32'b10_1001, rd, er);
    prev     = signal_stable_o;
    seen     = 0;
    waited   = 0;
    high_cnt = 0;
    while ((seen < 4) && (waited < 100))
    begin
      @(negedge adc_clk);
      waited++;
      if (signal_stable_o && !prev)
      begin
        seq[seen]     = mux_addr_o;   // address at each stable rise
        rise_at[seen] = waited;
        seen++;
      end
      if (signal_stable_o && (seen > 0) && (seen < 4))
        high_cnt++;                   // stable cycles of the first three stops
      prev = signal_stable_o;
    end
    if (seen < 4)
    begin
      $display("signal_stable_o rose only %0d of 4 times", seen);
      err_cnt++;
    end
    else
    begin
      check_mux("mux_addr_o step 0", seq[0], 3'd0);
      check_mux("mux_addr_o step 1", seq[1], 3'd3);
      check_mux("mux_addr_o step 2", seq[2], 3'd5);
      check_mux("mux_addr_o step 3", seq[3], 3'd0);   // wrapped
      for (int k = 1; k < 4; k++)
        check_cycles($sformatf("signal_stable_o period %0d", k), rise_at[k] - rise_at[k-1],
                     `MUX_SETTLE + MUX_DWELL_CYC);
      check_cycles("signal_stable_o high cycles", high_cnt, 3 * MUX_DWELL_CYC);
    end
    bus_access(1'b1, MUX_BASE | `BUS_W'(MUX_ACTIVE), 32'h0, rd, er);
    repeat (50)
    begin
      @(negedge adc_clk);
      check_mux("mux_addr_o idle", mux_addr_o, 3'd0);
      check_bit("signal_stable_o idle", signal_stable_o, 1'b0);
    end
    end_test("mux");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== fads_frontend.f ====
+incdir+source
source/fads_frontend_pkg.sv
source/sys_bus_decoder.sv
source/hk_regs.sv
source/channel_path.sv
source/dac_serializer.sv
source/mux_sequencer.sv
source/fads_frontend_top.sv
dv/fads_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: fads_frontend

sources:
  - include_dirs:
      - source
    files:
      - source/fads_frontend_pkg.sv
      - source/sys_bus_decoder.sv
      - source/hk_regs.sv
      - source/channel_path.sv
      - source/dac_serializer.sv
      - source/mux_sequencer.sv
      - source/fads_frontend_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/fads_frontend_tb.sv
